// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - design

sources:
  - files:
      - design/dcache_pkg.sv
      - design/dcache_ram.sv
      - design/dcache_ctrl.sv
      - design/dcache_bus_master.sv
      - design/dcache_top.sv
  - target: simulation
    files:
      - verification/wb_memory_model.sv
      - verification/tb_dcache.sv

// ==== design/dcache_bus_master.sv ====
module dcache_bus_master
	import dcache_pkg::*;
(
	input  logic        i_clock,
	input  logic        i_reset,

	// From and to the controller.
	input  mem_req_t    i_req,
	output mem_rsp_t    o_rsp,

	// Wishbone classic master.
	output logic        o_mem_cyc,
	output logic        o_mem_stb,
	output logic        o_mem_we,
	output logic [31:0] o_mem_adr,
	output logic [31:0] o_mem_dat,
	input  logic [31:0] i_mem_dat,
	input  logic        i_mem_ack
);

	logic        cyc_q;
	logic        done_q;
	logic [31:0] rdata_q;
	logic        start;

	// A held request is still valid in the done cycle, so skip it.
	assign start = i_req.valid && !cyc_q && !done_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			cyc_q  <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= cyc_q && i_mem_ack;
			if (cyc_q && i_mem_ack) begin
				cyc_q <= 1'b0;
			end else if (start) begin
				cyc_q <= 1'b1;
			end
		end
	end

	// Request fields and read data.
	always_ff @(posedge i_clock) begin
		if (start) begin
			o_mem_we  <= i_req.we;
			o_mem_adr <= i_req.adr;
			o_mem_dat <= i_req.dat;
		end
		if (cyc_q && i_mem_ack) begin
			rdata_q <= i_mem_dat;
		end
	end

	assign o_mem_cyc = cyc_q;
	assign o_mem_stb = cyc_q;
	assign o_rsp     = '{done: done_q, dat: rdata_q};

endmodule

// ==== design/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ========================================
// Cache geometry
// ========================================

// Line index width, taken from address bits above the byte offset.
`define DCACHE_INDEX_BITS 6

// Number of one-word lines.
`define DCACHE_LINES 64

// ========================================
// Address map
// ========================================

// Accesses with this address bit set bypass the cache.
`define DCACHE_UNCACHED_BIT 31

`endif

// ==== design/dcache_ctrl.sv ====
`include "dcache_consts.svh"

module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic                          i_clock,
	input  logic                          i_reset,

	// Processor port.
	input  logic                          i_cpu_cyc,
	input  logic                          i_cpu_stb,
	input  logic                          i_cpu_we,
	input  logic [31:0]                   i_cpu_adr,
	input  logic [31:0]                   i_cpu_dat,
	output logic [31:0]                   o_cpu_dat,
	output logic                          o_cpu_ack,
	input  logic                          i_flush,
	output logic                          o_flush_done,

	// Line storage.
	output logic                          o_ram_we,
	output logic [`DCACHE_INDEX_BITS-1:0] o_ram_index,
	output dcache_line_t                  o_ram_line,
	input  dcache_line_t                  i_ram_line,

	// Bus master.
	output mem_req_t                      o_req,
	input  mem_rsp_t                      i_rsp
);

	localparam logic [`DCACHE_INDEX_BITS-1:0] LAST_INDEX = `DCACHE_INDEX_BITS'(`DCACHE_LINES - 1);

	dcache_state_t state;
	dcache_state_t next_state;

	// Walks every line during initialization and flush.
	logic [`DCACHE_INDEX_BITS-1:0] line_count;
	logic [`DCACHE_INDEX_BITS-1:0] next_line_count;

	logic [29:0] cpu_tag;
	logic        cpu_uncached;
	logic        hit;
	logic        victim_dirty;
	mem_req_t    victim_req;

	assign cpu_tag      = i_cpu_adr[31:2];
	assign cpu_uncached = i_cpu_adr[`DCACHE_UNCACHED_BIT];
	assign hit          = i_ram_line.valid && (i_ram_line.tag == cpu_tag);
	assign victim_dirty = i_ram_line.valid && i_ram_line.dirty;

	// Write-back of whatever line storage currently shows.
	assign victim_req = '{
		valid: 1'b1,
		we:    1'b1,
		adr:   {i_ram_line.tag, 2'b00},
		dat:   i_ram_line.data
	};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state      <= INITIALIZE;
			line_count <= '0;
		end else begin
			state      <= next_state;
			line_count <= next_line_count;
		end
	end

	always_comb begin
		next_state      = state;
		next_line_count = line_count;

		o_cpu_dat    = '0;
		o_cpu_ack    = 1'b0;
		o_flush_done = 1'b0;

		o_ram_we    = 1'b0;
		o_ram_index = i_cpu_adr[`DCACHE_INDEX_BITS+1:2];
		o_ram_line  = '0;

		o_req = '0;

		case (state)
			// ========================================
			// Reset and idle
			// ========================================

			// Clear one line per cycle.
			INITIALIZE: begin
				o_ram_we        = 1'b1;
				o_ram_index     = line_count;
				next_line_count = line_count + 1'b1;
				if (line_count == LAST_INDEX) begin
					next_state = IDLE;
				end
			end

			IDLE: begin
				if (i_cpu_cyc && i_cpu_stb) begin
					if (cpu_uncached) begin
						next_state = PASS_THROUGH;
					end else if (i_cpu_we) begin
						next_state = WRITE_SETUP;
					end else begin
						next_state = READ_SETUP;
					end
				end else if (i_flush) begin
					next_line_count = '0;
					next_state      = FLUSH_SETUP;
				end
			end

			// Uncached, straight to memory.
			PASS_THROUGH: begin
				o_req     = '{valid: 1'b1, we: i_cpu_we, adr: i_cpu_adr, dat: i_cpu_dat};
				o_cpu_dat = i_rsp.dat;
				if (i_rsp.done) begin
					o_cpu_ack  = 1'b1;
					next_state = IDLE;
				end
			end

			// ========================================
			// Write allocate
			// ========================================

			WRITE_SETUP: begin
				o_ram_line = '{data: i_cpu_dat, tag: cpu_tag, dirty: 1'b1, valid: 1'b1};
				if (victim_dirty && !hit) begin
					o_req      = victim_req;
					next_state = WRITE_WB_WAIT;
				end else begin
					o_ram_we   = 1'b1;
					o_cpu_ack  = 1'b1;
					next_state = IDLE;
				end
			end

			// Victim going out, then install the new word.
			WRITE_WB_WAIT: begin
				o_req      = victim_req;
				o_ram_line = '{data: i_cpu_dat, tag: cpu_tag, dirty: 1'b1, valid: 1'b1};
				if (i_rsp.done) begin
					o_ram_we   = 1'b1;
					o_cpu_ack  = 1'b1;
					next_state = IDLE;
				end
			end

			// ========================================
			// Read
			// ========================================

			READ_SETUP: begin
				o_cpu_dat = i_ram_line.data;
				if (hit) begin
					o_cpu_ack  = 1'b1;
					next_state = IDLE;
				end else if (victim_dirty) begin
					o_req      = victim_req;
					next_state = READ_WB_WAIT;
				end else begin
					next_state = READ_BUS_WAIT;
				end
			end

			READ_WB_WAIT: begin
				o_req = victim_req;
				if (i_rsp.done) begin
					next_state = READ_BUS_WAIT;
				end
			end

			// Refill and answer from the bus data.
			READ_BUS_WAIT: begin
				o_req      = '{valid: 1'b1, we: 1'b0, adr: i_cpu_adr, dat: '0};
				o_cpu_dat  = i_rsp.dat;
				o_ram_line = '{data: i_rsp.dat, tag: cpu_tag, dirty: 1'b0, valid: 1'b1};
				if (i_rsp.done) begin
					o_ram_we   = 1'b1;
					o_cpu_ack  = 1'b1;
					next_state = IDLE;
				end
			end

			// ========================================
			// Flush
			// ========================================

			// Line shows up on the next cycle.
			FLUSH_SETUP: begin
				o_ram_index = line_count;
				next_state  = FLUSH_CHECK;
			end

			FLUSH_CHECK: begin
				o_ram_index = line_count;
				if (victim_dirty) begin
					o_req      = victim_req;
					next_state = FLUSH_WRITE;
				end else if (line_count == LAST_INDEX) begin
					o_flush_done = 1'b1;
					next_state   = IDLE;
				end else begin
					next_line_count = line_count + 1'b1;
					next_state      = FLUSH_SETUP;
				end
			end

			// Keep the line valid, just mark it clean.
			FLUSH_WRITE: begin
				o_ram_index = line_count;
				o_req       = victim_req;
				o_ram_line  = i_ram_line;
				o_ram_line.dirty = 1'b0;
				if (i_rsp.done) begin
					o_ram_we        = 1'b1;
					next_line_count = line_count + 1'b1;
					if (line_count == LAST_INDEX) begin
						o_flush_done = 1'b1;
						next_state   = IDLE;
					end else begin
						next_state = FLUSH_SETUP;
					end
				end
			end

			default: begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

// ==== design/dcache_pkg.sv ====
package dcache_pkg;

	// ========================================
	// Controller states
	// ========================================

	typedef enum logic [3:0] {
		INITIALIZE    = 4'd0,
		IDLE          = 4'd1,
		PASS_THROUGH  = 4'd2,
		WRITE_SETUP   = 4'd3,
		WRITE_WB_WAIT = 4'd4,
		READ_SETUP    = 4'd5,
		READ_WB_WAIT  = 4'd6,
		READ_BUS_WAIT = 4'd7,
		FLUSH_SETUP   = 4'd8,
		FLUSH_CHECK   = 4'd9,
		FLUSH_WRITE   = 4'd10
	} dcache_state_t;

	// ========================================
	// Line storage
	// ========================================

	// Tag holds the full word address of the cached word.
	typedef struct packed {
		logic [31:0] data;
		logic [29:0] tag;
		logic        dirty;
		logic        valid;
	} dcache_line_t;

	// ========================================
	// Memory request and response
	// ========================================

	typedef struct packed {
		logic        valid;
		logic        we;
		logic [31:0] adr;
		logic [31:0] dat;
	} mem_req_t;

	// Done pulses once, dat is only meaningful for reads.
	typedef struct packed {
		logic        done;
		logic [31:0] dat;
	} mem_rsp_t;

endpackage

// ==== design/dcache_ram.sv ====
`include "dcache_consts.svh"

module dcache_ram
	import dcache_pkg::*;
(
	input  logic                          i_clock,
	input  logic                          i_we,
	input  logic [`DCACHE_INDEX_BITS-1:0] i_index,
	input  dcache_line_t                  i_line,
	output dcache_line_t                  o_line
);

	// One entry per cache line.
	dcache_line_t lines [`DCACHE_LINES];

	// Write port.
	always_ff @(posedge i_clock) begin
		if (i_we) begin
			lines[i_index] <= i_line;
		end
	end

	// Registered read, old contents on a same-cycle write.
	always_ff @(posedge i_clock) begin
		o_line <= lines[i_index];
	end

endmodule

// ==== design/dcache_top.sv ====
`include "dcache_consts.svh"

module dcache_top
	import dcache_pkg::*;
(
	input  logic        i_clock,
	input  logic        i_reset,

	// Processor side.
	input  logic        i_cpu_cyc,
	input  logic        i_cpu_stb,
	input  logic        i_cpu_we,
	input  logic [31:0] i_cpu_adr,
	input  logic [31:0] i_cpu_dat,
	output logic [31:0] o_cpu_dat,
	output logic        o_cpu_ack,
	input  logic        i_flush,
	output logic        o_flush_done,

	// Memory side.
	output logic        o_mem_cyc,
	output logic        o_mem_stb,
	output logic        o_mem_we,
	output logic [31:0] o_mem_adr,
	output logic [31:0] o_mem_dat,
	input  logic [31:0] i_mem_dat,
	input  logic        i_mem_ack
);

	logic                          ram_we;
	logic [`DCACHE_INDEX_BITS-1:0] ram_index;
	dcache_line_t                  ram_wr_line;
	dcache_line_t                  ram_rd_line;
	mem_req_t                      mem_req;
	mem_rsp_t                      mem_rsp;

	dcache_ctrl dcache_ctrl_inst (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_cpu_cyc    (i_cpu_cyc),
		.i_cpu_stb    (i_cpu_stb),
		.i_cpu_we     (i_cpu_we),
		.i_cpu_adr    (i_cpu_adr),
		.i_cpu_dat    (i_cpu_dat),
		.o_cpu_dat    (o_cpu_dat),
		.o_cpu_ack    (o_cpu_ack),
		.i_flush      (i_flush),
		.o_flush_done (o_flush_done),
		.o_ram_we     (ram_we),
		.o_ram_index  (ram_index),
		.o_ram_line   (ram_wr_line),
		.i_ram_line   (ram_rd_line),
		.o_req        (mem_req),
		.i_rsp        (mem_rsp)
	);

	dcache_ram dcache_ram_inst (
		.i_clock (i_clock),
		.i_we    (ram_we),
		.i_index (ram_index),
		.i_line  (ram_wr_line),
		.o_line  (ram_rd_line)
	);

	dcache_bus_master dcache_bus_master_inst (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_req     (mem_req),
		.o_rsp     (mem_rsp),
		.o_mem_cyc (o_mem_cyc),
		.o_mem_stb (o_mem_stb),
		.o_mem_we  (o_mem_we),
		.o_mem_adr (o_mem_adr),
		.o_mem_dat (o_mem_dat),
		.i_mem_dat (i_mem_dat),
		.i_mem_ack (i_mem_ack)
	);

endmodule

// ==== verification/tb_dcache.sv ====
`include "dcache_consts.svh"

module tb_dcache;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int TIMEOUT_CYCLES = 1000;
	localparam int ROW_COUNT      = 19;

	typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_FLUSH} op_t;

	typedef struct packed {
		logic [8*20-1:0] name;
		op_t             op;
		logic [31:0]     adr;
		logic [31:0]     dat;
		logic [31:0]     exp;
	} row_t;

	logic        clock;
	logic        reset;
	logic        cpu_cyc;
	logic        cpu_stb;
	logic        cpu_we;
	logic [31:0] cpu_adr;
	logic [31:0] cpu_wdat;
	logic [31:0] cpu_rdat;
	logic        cpu_ack;
	logic        flush;
	logic        flush_done;
	logic        mem_cyc;
	logic        mem_stb;
	logic        mem_we;
	logic [31:0] mem_adr;
	logic [31:0] mem_wdat;
	logic [31:0] mem_rdat;
	logic        mem_ack;

	row_t rows [ROW_COUNT];
	int   cycle       = 0;
	int   ack_count   = 0;
	int   flush_count = 0;

	dcache_top dcache_top_inst (
		.i_clock      (clock),
		.i_reset      (reset),
		.i_cpu_cyc    (cpu_cyc),
		.i_cpu_stb    (cpu_stb),
		.i_cpu_we     (cpu_we),
		.i_cpu_adr    (cpu_adr),
		.i_cpu_dat    (cpu_wdat),
		.o_cpu_dat    (cpu_rdat),
		.o_cpu_ack    (cpu_ack),
		.i_flush      (flush),
		.o_flush_done (flush_done),
		.o_mem_cyc    (mem_cyc),
		.o_mem_stb    (mem_stb),
		.o_mem_we     (mem_we),
		.o_mem_adr    (mem_adr),
		.o_mem_dat    (mem_wdat),
		.i_mem_dat    (mem_rdat),
		.i_mem_ack    (mem_ack)
	);

	wb_memory_model wb_memory_model_inst (
		.i_clock (clock),
		.i_reset (reset),
		.i_cyc   (mem_cyc),
		.i_stb   (mem_stb),
		.i_we    (mem_we),
		.i_adr   (mem_adr),
		.i_dat   (mem_wdat),
		.o_dat   (mem_rdat),
		.o_ack   (mem_ack)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	// Every ack and flush done pulse, sampled mid-cycle.
	always @(negedge clock) begin
		if (cpu_ack) begin
			ack_count++;
		end
		if (flush_done) begin
			flush_count++;
		end
	end

	// Contents of an untouched memory word.
	function automatic logic [31:0] mem_pattern(input logic [31:0] adr);
		return {22'd0, adr[11:2]} ^ 32'h5EED_0000;
	endfunction

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// ========================================
	// Stimulus table
	// ========================================

	task automatic load_table();
		rows[0]  = '{"init_read_miss", OP_READ, 32'h0000_0010, 32'h0, mem_pattern(32'h10)};
		rows[1]  = '{"write_hit", OP_WRITE, 32'h0000_0010, 32'h1111_0001, 32'h0};
		rows[2]  = '{"read_back", OP_READ, 32'h0000_0010, 32'h0, 32'h1111_0001};
		rows[3]  = '{"read_hit_again", OP_READ, 32'h0000_0010, 32'h0, 32'h1111_0001};
		rows[4]  = '{"uncached_stale", OP_READ, 32'h8000_0010, 32'h0, mem_pattern(32'h10)};
		rows[5]  = '{"victim_write_a", OP_WRITE, 32'h0000_0120, 32'h2222_0002, 32'h0};
		rows[6]  = '{"victim_write_b", OP_WRITE, 32'h0000_0220, 32'h3333_0003, 32'h0};
		rows[7]  = '{"read_b", OP_READ, 32'h0000_0220, 32'h0, 32'h3333_0003};
		rows[8]  = '{"read_a", OP_READ, 32'h0000_0120, 32'h0, 32'h2222_0002};
		rows[9]  = '{"uncached_a", OP_READ, 32'h8000_0120, 32'h0, 32'h2222_0002};
		rows[10] = '{"uncached_write", OP_WRITE, 32'h8000_0300, 32'h4444_0004, 32'h0};
		rows[11] = '{"uncached_read", OP_READ, 32'h8000_0300, 32'h0, 32'h4444_0004};
		rows[12] = '{"flush_write_c", OP_WRITE, 32'h0000_0040, 32'h5555_0005, 32'h0};
		rows[13] = '{"flush", OP_FLUSH, 32'h0, 32'h0, 32'h0};
		rows[14] = '{"flushed_c", OP_READ, 32'h8000_0040, 32'h0, 32'h5555_0005};
		rows[15] = '{"flushed_x", OP_READ, 32'h8000_0010, 32'h0, 32'h1111_0001};
		rows[16] = '{"flushed_b", OP_READ, 32'h8000_0220, 32'h0, 32'h3333_0003};
		rows[17] = '{"flushed_a", OP_READ, 32'h8000_0120, 32'h0, 32'h2222_0002};
		rows[18] = '{"cached_after_flush", OP_READ, 32'h0000_0040, 32'h0, 32'h5555_0005};
	endtask

	// ========================================
	// Processor-side driver
	// ========================================

	task automatic transfer(input row_t row, output logic [31:0] rdata);
		int waited;
		waited = 0;
		cpu_cyc  <= 1'b1;
		cpu_stb  <= 1'b1;
		cpu_we   <= (row.op == OP_WRITE);
		cpu_adr  <= row.adr;
		cpu_wdat <= row.dat;
		@(negedge clock);
		while (!cpu_ack) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				stop_on_failure($sformatf("Timed out waiting for processor ack in %0s", row.name));
			end
			@(negedge clock);
		end
		rdata = cpu_rdat;
		@(posedge clock);
		cpu_cyc <= 1'b0;
		cpu_stb <= 1'b0;
	endtask

	task automatic run_flush();
		int waited;
		waited = 0;
		flush <= 1'b1;
		@(posedge clock);
		flush <= 1'b0;
		@(negedge clock);
		while (!flush_done) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				stop_on_failure("Timed out waiting for flush done");
			end
			@(negedge clock);
		end
		@(posedge clock);
	endtask

	initial begin
		logic [31:0] rdata;
		int          release_cycle;
		int          acks_expected;
		int          flushes_expected;
		acks_expected    = 0;
		flushes_expected = 0;
		reset    = 1'b1;
		cpu_cyc  = 1'b0;
		cpu_stb  = 1'b0;
		cpu_we   = 1'b0;
		cpu_adr  = '0;
		cpu_wdat = '0;
		flush    = 1'b0;
		load_table();

		repeat (16) @(posedge clock);
		reset <= 1'b0;
		release_cycle = cycle;

		for (int i = 0; i < ROW_COUNT; i++) begin
			@(posedge clock);
			// One idle cycle has passed, so a stray pulse would be counted.
			assert (ack_count == acks_expected && flush_count == flushes_expected)
				else stop_on_failure($sformatf("Extra ack or flush done before %0s", rows[i].name));
			if (rows[i].op == OP_FLUSH) begin
				run_flush();
				flushes_expected++;
			end else begin
				transfer(rows[i], rdata);
				acks_expected++;
				if (i == 0) begin
					assert (cycle - release_cycle > `DCACHE_LINES)
						else stop_on_failure("First transfer finished during line initialization");
				end
				if (rows[i].op == OP_READ) begin
					assert (rdata == rows[i].exp)
						else stop_on_failure($sformatf("[ERROR] %0s expected %h actual %h",
							rows[i].name, rows[i].exp, rdata));
				end
			end
		end

		@(posedge clock);
		assert (ack_count == acks_expected && flush_count == flushes_expected) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			stop_on_failure("Ack or flush done count differs from the rows applied");
		end
	end

endmodule

// ==== verification/wb_memory_model.sv ====
module wb_memory_model (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_cyc,
	input  logic        i_stb,
	input  logic        i_we,
	input  logic [31:0] i_adr,
	input  logic [31:0] i_dat,
	output logic [31:0] o_dat,
	output logic        o_ack
);
	timeunit 1ns;
	timeprecision 1ns;

	localparam logic [31:0] FILL_PATTERN = 32'h5EED_0000;

	// Word index is address bits 11 to 2 so bit 31 aliases.
	logic [31:0] words [1024];
	logic [31:0] seed;
	logic [31:0] seed_next;
	logic        pending;
	logic [1:0]  delay;

	function automatic logic [31:0] lcg_next(input logic [31:0] value);
		return value * 32'd1103515245 + 32'd12345;
	endfunction

	assign seed_next = lcg_next(seed);

	// Each transfer waits 0 to 3 extra cycles before ack.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ack   <= 1'b0;
			o_dat   <= '0;
			pending <= 1'b0;
			delay   <= '0;
			seed    <= 32'd63;
			for (int i = 0; i < 1024; i++) begin
				words[i] <= 32'(i) ^ FILL_PATTERN;
			end
		end else begin
			o_ack <= 1'b0;
			if (i_cyc && i_stb && !o_ack) begin
				if (!pending) begin
					seed    <= seed_next;
					delay   <= seed_next[17:16];
					pending <= 1'b1;
				end else if (delay != 2'd0) begin
					delay <= delay - 1'b1;
				end else begin
					pending <= 1'b0;
					o_ack   <= 1'b1;
					o_dat   <= words[i_adr[11:2]];
					if (i_we) begin
						words[i_adr[11:2]] <= i_dat;
					end
				end
			end
		end
	end

endmodule

// ==== vlog.f ====
+incdir+design
design/dcache_pkg.sv
design/dcache_ram.sv
design/dcache_ctrl.sv
design/dcache_bus_master.sv
design/dcache_top.sv
verification/wb_memory_model.sv
verification/tb_dcache.sv
